/* compile.f */
hdl/inq_pkg.sv
hdl/inq_rf16x128d.sv
hdl/inq_wl_ctl.sv
hdl/inq_csr.sv
hdl/inq_top.sv
sim/inq_assertions.sv
sim/inq_tb.sv

/* Makefile */
# Verilator build and run for the inbound queue testbench

VERILATOR ?= verilator
TOP       ?= inq_tb
FILELIST  ?= compile.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_STR  ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_STR)" $(LOG); then \
	  echo "PASS"; \
	else \
	  echo "FAIL"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/inq_tb.sv */
// queue testbench with clock, reset, stimulus tasks, reference model and monitor
`default_nettype none

module inq_tb
  import inq_pkg::*;
;

  localparam int DATA_W = 128;
  localparam int TMO    = 400;             // cycles per wait
  localparam int M_PUSH = 0;
  localparam int M_POP  = 1;
  localparam int M_CNT  = 2;
  localparam int M_WMK  = 3;
  localparam int M_CLR  = 4;
  localparam int M_FLSH = 5;
  localparam int M_TICK = 6;
  localparam int M_RDRG = 7;

  logic                  rclk;
  logic                  reset_l;
  logic                  push_valid;
  logic [DATA_W-1:0]     push_data;
  logic                  push_ready;
  logic                  pop_valid;
  logic [DATA_W-1:0]     pop_data;
  logic                  pop_ready;
  logic                  csr_valid;
  csr_op_e               csr_op;
  csr_addr_e             csr_addr;
  logic [csr_data_w-1:0] csr_wdata;
  logic [csr_data_w-1:0] csr_rdata;
  logic                  csr_rvalid;
  logic                  almost_full;

  // model state
  logic [DATA_W-1:0] exp_q[$];
  logic              pend_m  = 1'b0;     // push accepted but not yet committed
  int                tally   = 0;
  int                wmark_m = 12;

  // monitor state
  int                cyc       = 0;
  int                acc_edge  = 0;
  int                pop_mode  = 0;      // 0 holds pop_ready low, 1 randomizes it and 2 keeps it high
  bit                mon_en    = 1'b0;
  bit                flush_arm = 1'b0;
  bit                flush_now;
  bit                rd_pend   = 1'b0;
  logic [DATA_W-1:0] rd_exp;
  bit                after_pop = 1'b0;
  bit                gap_chk   = 1'b0;
  bit                prev_pv   = 1'b0;
  bit                prev_pr   = 1'b0;
  logic [DATA_W-1:0] prev_pd;

  inq_top #(.DATA_W(DATA_W)) dut (.*);

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function logic [DATA_W-1:0] inq_model(input int op, input logic [DATA_W-1:0] wd);
    logic [DATA_W-1:0] r;
    int                cnt;
    r   = '0;
    cnt = exp_q.size() - int'(pend_m);   // committed count
    case (op)
      M_PUSH: begin
        exp_q.push_back(wd);
        tally = tally + 1;
      end
      M_POP:  if (exp_q.size() > 0) r = exp_q.pop_front();
      M_CNT:  r = DATA_W'(cnt);
      M_WMK:  wmark_m = int'(wd[INQ_CNT_W-1:0]);  // register is 5 bits wide
      M_CLR:  tally = 0;
      M_FLSH: begin
        exp_q.delete();
        pend_m = 1'b0;
      end
      M_TICK: pend_m = wd[0];
      M_RDRG: begin
        case (csr_addr_e'(wd[1:0]))
          csr_wmark:   r = DATA_W'(wmark_m);
          csr_status:  r = DATA_W'(cnt);
          csr_pushcnt: r = DATA_W'(tally % 65536);
          default:     r = '0;               // ctl reads zero
        endcase
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  //////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic mismatch(input string name, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] got);
    report_fail($sformatf("MISMATCH %s expected %0h got %0h", name, exp, got));
  endtask

  //////////////////////////////////////////////////
  // clock, cycle count, consumer
  //////////////////////////////////////////////////

  initial begin
    rclk = 1'b0;
    forever #50 rclk = ~rclk;
  end

  always @(posedge rclk) cyc <= cyc + 1;

  always @(posedge rclk) begin
    case (pop_mode)
      1:       pop_ready <= 1'($urandom % 2);
      2:       pop_ready <= 1'b1;
      default: pop_ready <= 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // monitor sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge rclk) begin
    logic [DATA_W-1:0] e;
    int                cnt_m;
    bit                pfire;
    bit                ufire;
    bit                gap_nxt;
    bit                rdy_exp;
    if (mon_en) begin
      flush_now = flush_arm;               // flush pulse is in this cycle
      flush_arm = 1'b0;
      cnt_m     = int'(inq_model(M_CNT, '0));
      pfire     = pop_valid && pop_ready;
      ufire     = push_valid && push_ready;
      rdy_exp   = (exp_q.size() < INQ_ENTRIES) && !flush_now;

      assert (almost_full == (cnt_m >= wmark_m))
        else mismatch("almost_full", DATA_W'(cnt_m >= wmark_m), DATA_W'(almost_full));
      assert (push_ready == rdy_exp)
        else mismatch("push_ready", DATA_W'(rdy_exp), DATA_W'(push_ready));
      if (cnt_m == 0)
        assert (!pop_valid) else report_fail("pop_valid high on an empty queue");
      if (after_pop)
        assert (!pop_valid) else report_fail("pop_valid not low in the cycle after a pop");
      if (gap_chk)
        assert (pop_valid) else report_fail("pop_valid low for more than one cycle after a pop");

      // back-pressure hold
      if (prev_pv && !prev_pr && !flush_now) begin
        assert (pop_valid) else report_fail("pop_valid dropped under back-pressure");
        assert (pop_data == prev_pd) else mismatch("pop_data", prev_pd, pop_data);
      end

      // register read return
      if (rd_pend) begin
        assert (csr_rvalid) else report_fail("csr_rvalid missing after a read command");
        assert (csr_rdata == csr_data_w'(rd_exp))
          else mismatch("csr_rdata", rd_exp, DATA_W'(csr_rdata));
      end else begin
        assert (!csr_rvalid) else report_fail("csr_rvalid high without a read command");
      end
      rd_pend = csr_valid && (csr_op == csr_rd);
      if (rd_pend) rd_exp = inq_model(M_RDRG, DATA_W'(csr_addr));  // pre-edge values

      if (pfire) begin
        assert (cnt_m > 0) else report_fail("pop accepted with no committed word");
        e = inq_model(M_POP, '0);
        assert (pop_data == e) else mismatch("pop_data", e, pop_data);
      end
      if (ufire) begin
        e        = inq_model(M_PUSH, push_data);
        acc_edge = cyc + 1;
      end

      // register writes land on the same edge
      if (csr_valid && (csr_op == csr_wr)) begin
        case (csr_addr)
          csr_wmark:   e = inq_model(M_WMK, DATA_W'(csr_wdata));
          csr_pushcnt: e = inq_model(M_CLR, '0);   // clear beats a push
          csr_ctl:     flush_arm = csr_wdata[0];
          default:     e = '0;
        endcase
      end

      e = inq_model(M_TICK, DATA_W'(ufire));
      if (flush_now) e = inq_model(M_FLSH, '0);

      gap_nxt   = after_pop && (cnt_m > 0) && !flush_now && !flush_arm;
      gap_chk   = gap_nxt;
      after_pop = pfire;
      prev_pv   = pop_valid;
      prev_pr   = pop_ready;
      prev_pd   = pop_data;
    end
  end

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    for (int i = 0; i < DATA_W / 32; i++) w[i*32 +: 32] = $urandom;
    return w;
  endfunction

  task automatic push_word(input logic [DATA_W-1:0] w);
    int n;
    n = 0;
    @(posedge rclk);
    push_valid <= 1'b1;
    push_data  <= w;
    @(negedge rclk);
    while (!push_ready) begin
      n++;
      if (n > TMO) report_fail("timeout waiting for push_ready");
      @(negedge rclk);
    end
    @(posedge rclk);                       // word transfers here
    push_valid <= 1'b0;
  endtask

  task automatic csr_write(input csr_addr_e a, input logic [csr_data_w-1:0] d);
    @(posedge rclk);
    csr_valid <= 1'b1;
    csr_op    <= csr_wr;
    csr_addr  <= a;
    csr_wdata <= d;
    @(posedge rclk);
    csr_valid <= 1'b0;
    csr_op    <= csr_nop;
  endtask

  task automatic csr_read(input csr_addr_e a);
    int n;
    n = 0;
    @(posedge rclk);
    csr_valid <= 1'b1;
    csr_op    <= csr_rd;
    csr_addr  <= a;
    @(posedge rclk);
    csr_valid <= 1'b0;
    csr_op    <= csr_nop;
    @(negedge rclk);
    while (!csr_rvalid) begin
      n++;
      if (n > TMO) report_fail("timeout waiting for csr_rvalid");
      @(negedge rclk);
    end
  endtask

  task automatic wait_empty();
    int n;
    n = 0;
    @(negedge rclk);
    while ((exp_q.size() != 0) || push_valid) begin
      n++;
      if (n > TMO * 4) report_fail("timeout waiting for the queue to drain");
      @(negedge rclk);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int n;
    int v;
    reset_l    = 1'b1;
    push_valid = 1'b0;
    push_data  = '0;
    pop_ready  = 1'b0;
    csr_valid  = 1'b0;
    csr_op     = csr_nop;
    csr_addr   = csr_ctl;
    csr_wdata  = '0;
    void'($urandom(32'h6c9a_db4c));

    // outputs idle while reset is held
    @(posedge rclk);
    repeat (7) begin
      @(negedge rclk);
      assert (!push_ready && !pop_valid && !csr_rvalid && !almost_full)
        else report_fail("outputs not idle during reset");
      assert (pop_data == '0) else mismatch("pop_data", '0, pop_data);
      @(posedge rclk);
    end
    reset_l <= 1'b0;
    repeat (2) @(posedge rclk);
    mon_en = 1'b1;

    // order and integrity under random back-pressure
    @(negedge rclk);
    pop_mode = 1;
    repeat (150) begin
      push_word(rand_word());
      repeat ($urandom % 3) @(posedge rclk);
    end
    wait_empty();

    // fill to 16 then drain
    pop_mode = 0;
    repeat (16) push_word(rand_word());
    repeat (4) begin
      @(negedge rclk);
      assert (!push_ready) else report_fail("push_ready high with 16 words queued");
    end
    pop_mode = 2;
    wait_empty();

    // latency from push into empty queue
    repeat (4) @(posedge rclk);
    push_word(rand_word());
    n = 0;
    @(negedge rclk);
    while (!pop_valid) begin
      n++;
      if (n > TMO) report_fail("timeout waiting for pop_valid");
      @(negedge rclk);
    end
    assert (cyc - acc_edge == 2) else mismatch("pop_valid latency", 2, DATA_W'(cyc - acc_edge));
    repeat (6) push_word(rand_word());     // gap rule checked while draining
    wait_empty();

    // watermark sweep
    repeat (12) begin
      v = $urandom % 17;
      csr_write(csr_wmark, csr_data_w'(v));
      csr_read(csr_wmark);
      pop_mode = (exp_q.size() > 12) ? 1 : int'($urandom % 2);
      repeat (1 + $urandom % 3) push_word(rand_word());
      csr_read(csr_status);
    end
    pop_mode = 2;
    wait_empty();

    // status and push counter
    csr_read(csr_status);
    csr_read(csr_pushcnt);
    csr_write(csr_pushcnt, '0);
    csr_read(csr_pushcnt);
    pop_mode = 0;
    repeat (3) push_word(rand_word());
    repeat (2) @(posedge rclk);
    csr_read(csr_pushcnt);
    csr_read(csr_status);
    pop_mode = 2;
    wait_empty();

    // flush a partly filled queue
    pop_mode = 0;
    repeat (10) push_word(rand_word());
    repeat (3) @(posedge rclk);
    csr_write(csr_ctl, 16'h0001);
    repeat (3) @(posedge rclk);
    csr_read(csr_status);
    @(negedge rclk);
    assert (!pop_valid) else report_fail("pop_valid high after flush");
    pop_mode = 2;
    repeat (5) push_word(rand_word());
    wait_empty();

    repeat (5) @(posedge rclk);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/inq_assertions.sv */
// concurrent checks on wordlines, read/write overlap, pop hold and full flow control, with the bind
`default_nettype none

module inq_assertions
  import inq_pkg::*;
(
  input wire                   rclk,
  input wire                   reset_l,
  input wire [INQ_ENTRIES-1:0] wr_wl,
  input wire [INQ_ENTRIES-1:0] rd_wl,
  input wire                   pop_valid,
  input wire                   pop_ready,
  input wire                   push_ready,
  input wire                   flush,
  input wire [INQ_CNT_W-1:0]   cnt_q,
  input wire                   pend_q
);

  //////////////////////////////////////////////////
  // wordline shape
  //////////////////////////////////////////////////

  wr_wl_onehot: assert property (@(posedge rclk) disable iff (reset_l) $onehot0(wr_wl))
    else $error("write wordline has more than one bit set");

  rd_wl_onehot: assert property (@(posedge rclk) disable iff (reset_l) $onehot0(rd_wl))
    else $error("read wordline has more than one bit set");

  // a pending entry is never the head while readable
  no_rw_overlap: assert property (@(posedge rclk) disable iff (reset_l)
    ((wr_wl & rd_wl) == '0))
    else $error("read and write wordlines select the same entry");

  //////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////

  // head held under back-pressure keeps the array output
  pop_hold: assert property (@(posedge rclk) disable iff (reset_l)
    (pop_valid && !pop_ready && !flush) |=> ((pop_valid || flush) && $stable(rd_wl)))
    else $error("pop_valid or read wordline changed under back-pressure");

  full_no_ready: assert property (@(posedge rclk) disable iff (reset_l)
    (({1'b0, cnt_q} + INQ_CNT_W'(pend_q)) >= INQ_ENTRIES) |-> !push_ready)
    else $error("push_ready high with all entries taken");

endmodule

bind inq_wl_ctl inq_assertions u_assert (
  .rclk       (rclk),
  .reset_l    (reset_l),
  .wr_wl      (wr_wl),
  .rd_wl      (rd_wl),
  .pop_valid  (pop_valid),
  .pop_ready  (pop_ready),
  .push_ready (push_ready),
  .flush      (flush),
  .cnt_q      (cnt_q),
  .pend_q     (pend_q)
);

`default_nettype wire

/* hdl/inq_top.sv */
// module: queue top level, control block, register file and command register block
`default_nettype none

module inq_top
  import inq_pkg::*;
#(
  parameter int DATA_W = 128
) (
  input  wire                   rclk,
  input  wire                   reset_l,
  // push side
  input  wire                   push_valid,
  input  wire  [DATA_W-1:0]     push_data,
  output logic                  push_ready,
  // pop side
  output logic                  pop_valid,
  output logic [DATA_W-1:0]     pop_data,
  input  wire                   pop_ready,
  // command bus
  input  wire                   csr_valid,
  input  var  csr_op_e          csr_op,
  input  var  csr_addr_e        csr_addr,
  input  wire  [csr_data_w-1:0] csr_wdata,
  output logic [csr_data_w-1:0] csr_rdata,
  output logic                  csr_rvalid,
  output logic                  almost_full
);

  logic [INQ_ENTRIES-1:0] wr_wl;
  logic [INQ_ENTRIES-1:0] rd_wl;
  logic                   wr_en;
  logic                   read_en;
  logic [INQ_CNT_W-1:0]   count;
  logic                   push_fire;
  logic                   flush;
  logic [INQ_CNT_W-1:0]   wmark;

  inq_wl_ctl u_ctl (
    .rclk        (rclk),
    .reset_l     (reset_l),
    .push_valid  (push_valid),
    .pop_ready   (pop_ready),
    .flush       (flush),
    .wmark       (wmark),
    .push_ready  (push_ready),
    .pop_valid   (pop_valid),
    .wr_wl       (wr_wl),
    .wr_en       (wr_en),
    .rd_wl       (rd_wl),
    .read_en     (read_en),
    .count       (count),
    .push_fire   (push_fire),
    .almost_full (almost_full)
  );

  inq_rf16x128d #(.DATA_W(DATA_W)) u_rf (
    .rclk    (rclk),
    .reset_l (reset_l),
    .din     (push_data),      // straight from the push port
    .rd_wl   (rd_wl),
    .wr_wl   (wr_wl),
    .read_en (read_en),
    .wr_en   (wr_en),
    .dout    (pop_data)
  );

  inq_csr u_csr (
    .rclk       (rclk),
    .reset_l    (reset_l),
    .csr_valid  (csr_valid),
    .csr_op     (csr_op),
    .csr_addr   (csr_addr),
    .csr_wdata  (csr_wdata),
    .count      (count),
    .push_fire  (push_fire),
    .csr_rdata  (csr_rdata),
    .csr_rvalid (csr_rvalid),
    .flush      (flush),
    .wmark      (wmark)
  );

endmodule

`default_nettype wire

/* hdl/inq_csr.sv */
// module: command bus register block with watermark, flush pulse, status and push counter
`default_nettype none

module inq_csr
  import inq_pkg::*;
(
  input  wire                   rclk,
  input  wire                   reset_l,
  input  wire                   csr_valid,
  input  var  csr_op_e          csr_op,
  input  var  csr_addr_e        csr_addr,
  input  wire  [csr_data_w-1:0] csr_wdata,
  input  wire  [INQ_CNT_W-1:0]  count,        // committed fill count
  input  wire                   push_fire,
  output logic [csr_data_w-1:0] csr_rdata,
  output logic                  csr_rvalid,
  output logic                  flush,
  output logic [INQ_CNT_W-1:0]  wmark
);

  localparam logic [INQ_CNT_W-1:0] WMARK_RST = INQ_CNT_W'(12);

  logic                  rd_cmd;
  logic                  wr_cmd;
  logic [csr_data_w-1:0] pushcnt_q;
  logic [csr_data_w-1:0] rd_mux;

  //////////////////////////////////////////////////
  // command decode
  //////////////////////////////////////////////////

  always_comb begin
    rd_cmd = 1'b0;
    wr_cmd = 1'b0;
    case (csr_op)
      csr_rd:  rd_cmd = csr_valid;
      csr_wr:  wr_cmd = csr_valid;
      csr_nop: ;                                  // idle
      default: ;
    endcase
  end

  // read data select, unlisted bits zero
  always_comb begin
    case (csr_addr)
      csr_wmark:   rd_mux = csr_data_w'(wmark);
      csr_status:  rd_mux = csr_data_w'(count);
      csr_pushcnt: rd_mux = pushcnt_q;
      default:     rd_mux = '0;                   // csr_ctl write only
    endcase
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge rclk) begin
    if (reset_l) begin
      wmark      <= WMARK_RST;
      pushcnt_q  <= '0;
      flush      <= 1'b0;
      csr_rvalid <= 1'b0;
      csr_rdata  <= '0;
    end else begin
      flush      <= wr_cmd && (csr_addr == csr_ctl) && csr_wdata[0];
      csr_rvalid <= rd_cmd;
      csr_rdata  <= rd_cmd ? rd_mux : '0;         // one cycle, with rvalid
      if (wr_cmd && (csr_addr == csr_wmark)) wmark <= csr_wdata[INQ_CNT_W-1:0];
      // clear wins over a push in the same cycle
      if (wr_cmd && (csr_addr == csr_pushcnt))
        pushcnt_q <= '0;
      else if (push_fire)
        pushcnt_q <= pushcnt_q + 1'b1;            // wraps at 16 bits
    end
  end

endmodule

`default_nettype wire

/* hdl/inq_wl_ctl.sv */
// module: head/tail one-hot wordline pointers, pending and committed counts, push and pop handshakes
`default_nettype none

module inq_wl_ctl
  import inq_pkg::*;
(
  input  wire                    rclk,
  input  wire                    reset_l,
  input  wire                    push_valid,
  input  wire                    pop_ready,
  input  wire                    flush,        // one-cycle pulse from csr
  input  wire  [INQ_CNT_W-1:0]   wmark,
  output logic                   push_ready,
  output logic                   pop_valid,
  output logic [INQ_ENTRIES-1:0] wr_wl,
  output logic                   wr_en,
  output logic [INQ_ENTRIES-1:0] rd_wl,
  output logic                   read_en,
  output logic [INQ_CNT_W-1:0]   count,
  output logic                   push_fire,
  output logic                   almost_full
);

  logic [INQ_ENTRIES-1:0] tail_wl;     // next entry to write
  logic [INQ_ENTRIES-1:0] head_wl;     // oldest entry
  logic                   pend_q;      // push accepted, array write next edge
  logic [INQ_CNT_W-1:0]   cnt_q;       // entries present in the array
  logic [INQ_CNT_W-1:0]   occ_nxt;
  logic                   room_q;
  logic                   rd_ok_q;     // read wordline settled in the array
  logic                   pop_fire;

  //////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////

  // nothing transfers in the flush cycle
  assign push_ready = room_q & ~flush;
  assign push_fire  = push_valid & push_ready;

  assign read_en   = (cnt_q != '0);                  // only committed entries
  assign pop_valid = read_en & rd_ok_q & ~flush;
  assign pop_fire  = pop_valid & pop_ready;

  //////////////////////////////////////////////////
  // wordlines toward the array
  //////////////////////////////////////////////////

  assign wr_en = push_fire;
  assign wr_wl = tail_wl & {INQ_ENTRIES{push_fire}};
  assign rd_wl = head_wl & {INQ_ENTRIES{read_en}};   // zero when empty

  assign count       = cnt_q;
  assign almost_full = (cnt_q >= wmark);

  // total occupancy after this edge, pending write included
  assign occ_nxt = cnt_q + INQ_CNT_W'(pend_q) + INQ_CNT_W'(push_fire)
                 - INQ_CNT_W'(pop_fire);

  //////////////////////////////////////////////////
  // pointer and count state
  //////////////////////////////////////////////////

  always_ff @(posedge rclk) begin
    if (reset_l) begin
      tail_wl <= INQ_ENTRIES'(1);
      head_wl <= INQ_ENTRIES'(1);
      pend_q  <= 1'b0;
      cnt_q   <= '0;
      room_q  <= 1'b0;                               // ready low through reset
      rd_ok_q <= 1'b0;
    end else if (flush) begin
      // back to entry 0, pending write dropped
      tail_wl <= INQ_ENTRIES'(1);
      head_wl <= INQ_ENTRIES'(1);
      pend_q  <= 1'b0;
      cnt_q   <= '0;
      room_q  <= 1'b1;
      rd_ok_q <= 1'b0;
    end else begin
      if (push_fire) begin
        tail_wl <= {tail_wl[INQ_ENTRIES-2:0], tail_wl[INQ_ENTRIES-1]};  // rotate
      end
      if (pop_fire) begin
        head_wl <= {head_wl[INQ_ENTRIES-2:0], head_wl[INQ_ENTRIES-1]};
      end
      pend_q  <= push_fire;
      cnt_q   <= cnt_q + INQ_CNT_W'(pend_q) - INQ_CNT_W'(pop_fire);  // commit lags one
      room_q  <= (occ_nxt < INQ_ENTRIES);
      // wordline presented this cycle and head unchanged at the edge
      rd_ok_q <= read_en & ~pop_fire;
    end
  end

endmodule

`default_nettype wire

/* hdl/inq_rf16x128d.sv */
// module: 16-entry register file with flopped decoded wordlines, flopped write data, one read port
`default_nettype none

module inq_rf16x128d
  import inq_pkg::*;
#(
  parameter int DATA_W = 128
) (
  input  wire                    rclk,
  input  wire                    reset_l,
  input  wire  [DATA_W-1:0]      din,       // write data
  input  wire  [INQ_ENTRIES-1:0] rd_wl,     // read wordline, one-hot or zero
  input  wire  [INQ_ENTRIES-1:0] wr_wl,     // write wordline, one-hot or zero
  input  wire                    read_en,
  input  wire                    wr_en,
  output logic [DATA_W-1:0]      dout
);

  logic [DATA_W-1:0]      ary [INQ_ENTRIES];   // storage, no reset
  logic [DATA_W-1:0]      wrdata_d1;
  logic [DATA_W-1:0]      dout_hold;           // last word read
  logic [INQ_ENTRIES-1:0] rd_wl_d1;
  logic [INQ_ENTRIES-1:0] wr_wl_d1;
  logic                   ren_d1;
  logic                   wr_en_d1;
  logic [INQ_PTR_W-1:0]   rd_idx;
  logic                   rd_hit;

  //////////////////////////////////////////////////
  // input flops
  //////////////////////////////////////////////////

  always_ff @(posedge rclk) begin
    wrdata_d1 <= din;                          // payload only
    if (reset_l) begin
      rd_wl_d1 <= '0;
      wr_wl_d1 <= '0;
      ren_d1   <= 1'b0;
      wr_en_d1 <= 1'b0;
    end else begin
      rd_wl_d1 <= rd_wl;
      wr_wl_d1 <= wr_wl;
      ren_d1   <= read_en;
      wr_en_d1 <= wr_en;
    end
  end

  //////////////////////////////////////////////////
  // write, one edge after the flopped wordline
  //////////////////////////////////////////////////

  always_ff @(posedge rclk) begin
    if (wr_en_d1) begin
      for (int i = 0; i < INQ_ENTRIES; i++) begin
        if (wr_wl_d1[i]) ary[i] <= wrdata_d1;  // zero wordline, no write
      end
    end
  end

  //////////////////////////////////////////////////
  // read
  //////////////////////////////////////////////////

  // one-hot to index
  always_comb begin
    rd_idx = '0;
    rd_hit = 1'b0;
    for (int i = 0; i < INQ_ENTRIES; i++) begin
      if (rd_wl_d1[i]) begin
        rd_idx = INQ_PTR_W'(i);
        rd_hit = 1'b1;
      end
    end
  end

  // held copy for cycles with no access
  always_ff @(posedge rclk) begin
    if (ren_d1 && rd_hit) dout_hold <= ary[rd_idx];
  end

  always_comb begin
    if (reset_l)
      dout = '0;                               // forced low in reset
    else if (ren_d1 && rd_hit)
      dout = ary[rd_idx];                      // live read of selected entry
    else
      dout = dout_hold;
  end

endmodule

`default_nettype wire

/* hdl/inq_pkg.sv */
// package: queue geometry constants, command bus width, bus opcode and register address enums
`default_nettype none

package inq_pkg;

  //////////////////////////////////////////////////
  // queue geometry
  //////////////////////////////////////////////////

  parameter int INQ_ENTRIES = 16;   // array depth, one wordline per entry
  parameter int INQ_PTR_W   = 4;    // encoded entry index
  parameter int INQ_CNT_W   = 5;    // fill count, must reach INQ_ENTRIES

  //////////////////////////////////////////////////
  // command bus
  //////////////////////////////////////////////////

  parameter int csr_data_w = 16;    // read and write data width

  // bus opcodes
  typedef enum logic [1:0] {
    csr_nop = 2'd0,                 // idle slot
    csr_rd  = 2'd1,
    csr_wr  = 2'd2
  } csr_op_e;

  // register map
  typedef enum logic [1:0] {
    csr_ctl     = 2'd0,             // bit 0 flush, write only
    csr_wmark   = 2'd1,             // almost_full threshold
    csr_status  = 2'd2,             // committed fill count, read only
    csr_pushcnt = 2'd3              // accepted pushes, write clears
  } csr_addr_e;

endpackage

`default_nettype wire
